// ==== src/fabric_pkg.sv ====
// Shared bus types and the address map of the single-master bus fabric

package fabric_pkg;

	// Word address and data word on the shared bus
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// LED bank, also the width of the switch and button inputs
	typedef logic [3:0] led_t;

	//////////////////////////////////////////////////////////////////////
	// Address map, in words
	//////////////////////////////////////////////////////////////////////

	// Board I/O window, eight words
	localparam addr_t IO_BASE = 32'h0000_0100;

	// Single counter word, just past the I/O window
	localparam addr_t CNT_BASE = 32'h0000_0108;

	// RAM base, aligned to the RAM size
	localparam addr_t RAM_BASE = 32'h0000_2000;

	// Register offsets inside the I/O window
	localparam logic [2:0] IO_SW_REG  = 3'd0;
	localparam logic [2:0] IO_LED_REG = 3'd1;
	// Address of the last unmapped access
	localparam logic [2:0] IO_ERR_REG = 3'd2;

endpackage

// ==== src/addr_decoder.sv ====
// Address decoder for the bus fabric
// One strobe per slave, plus a miss strobe for unmapped addresses

module addr_decoder #(
	parameter int RAM_AW = 10
) (
	input  logic              i_cyc,
	input  logic              i_stb,
	input  fabric_pkg::addr_t i_addr,
	output logic              o_ram_stb,
	output logic              o_io_stb,
	output logic              o_cnt_stb,
	output logic              o_miss_stb
);
	import fabric_pkg::*;

	logic bus_stb;
	logic ram_hit;
	logic io_hit;
	logic cnt_hit;

	// Strobe only counts inside a cycle
	assign bus_stb = i_cyc && i_stb;

	//////////////////////////////////////////////////////////////////////
	// Region compares
	//////////////////////////////////////////////////////////////////////

	// RAM region of 2^RAM_AW words
	assign ram_hit = (i_addr >> RAM_AW) == (RAM_BASE >> RAM_AW);
	// Eight word I/O window
	assign io_hit = (i_addr >> 3) == (IO_BASE >> 3);
	// Exactly one counter word
	assign cnt_hit = (i_addr == CNT_BASE);

	// Regions are disjoint, so at most one strobe
	assign o_ram_stb = bus_stb && ram_hit;
	assign o_io_stb  = bus_stb && io_hit;
	assign o_cnt_stb = bus_stb && cnt_hit;

	// Nothing matched, answer with a bus error later
	assign o_miss_stb = bus_stb && !(ram_hit || io_hit || cnt_hit);

endmodule

// ==== src/resp_mux.sv ====
// Response path back to the master
// Registered ack and read data, plus the delayed bus error pulse

module resp_mux (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_ram_ack,
	input  logic              i_io_ack,
	input  logic              i_cnt_ack,
	input  fabric_pkg::data_t i_ram_data,
	input  fabric_pkg::data_t i_io_data,
	input  fabric_pkg::data_t i_cnt_data,
	input  logic              i_miss_stb,
	output logic              o_ack,
	output logic              o_err,
	output fabric_pkg::data_t o_rdata
);
	import fabric_pkg::*;

	// First stage of the miss pipe, lines up with the slave acks
	logic miss_q;

	//////////////////////////////////////////////////////////////////////
	// Ack and error flops
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_ack  <= 1'b0;
			miss_q <= 1'b0;
			o_err  <= 1'b0;
		end
		else
		begin
			o_ack  <= i_ram_ack || i_io_ack || i_cnt_ack;
			miss_q <= i_miss_stb;
			// Two clocks after the miss, same slot as an ack
			o_err  <= miss_q;
		end
	end

	// Read data select, RAM first, then I/O, then counter
	always_ff @(posedge i_clk)
	begin
		if (i_ram_ack)
			o_rdata <= i_ram_data;
		else if (i_io_ack)
			o_rdata <= i_io_data;
		else
			o_rdata <= i_cnt_data;
	end

endmodule

// ==== src/block_ram.sv ====
// Block RAM slave, single port, word wide
// Ack and read data one clock after the strobe

module block_ram #(
	parameter int RAM_AW = 10
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_stb,
	input  logic              i_we,
	input  logic [RAM_AW-1:0] i_addr,
	input  fabric_pkg::data_t i_wdata,
	output logic              o_ack,
	output fabric_pkg::data_t o_rdata
);
	import fabric_pkg::*;

	localparam int DEPTH = 2 ** RAM_AW;

	// Word storage
	data_t mem [DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Memory array
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_stb && i_we)
			mem[i_addr] <= i_wdata;
		// Old contents on a write strobe
		if (i_stb)
			o_rdata <= mem[i_addr];
	end

	// Ack is the strobe, one clock late
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_ack <= 1'b0;
		else
			o_ack <= i_stb;
	end

endmodule

// ==== src/board_io.sv ====
// Board I/O slave: switches, buttons, LED register
// Also holds the address of the last unmapped access

module board_io (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_stb,
	input  logic              i_we,
	input  logic [2:0]        i_offset,
	input  fabric_pkg::data_t i_wdata,
	input  fabric_pkg::led_t  i_sw,
	input  fabric_pkg::led_t  i_btn,
	input  logic              i_miss_stb,
	input  fabric_pkg::addr_t i_bus_addr,
	output logic              o_ack,
	output fabric_pkg::data_t o_rdata,
	output fabric_pkg::led_t  o_led
);
	import fabric_pkg::*;

	data_t led_reg;
	addr_t err_addr;

	//////////////////////////////////////////////////////////////////////
	// Control registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_ack    <= 1'b0;
			led_reg  <= '0;
			err_addr <= '0;
		end
		else
		begin
			o_ack <= i_stb;
			if (i_stb && i_we && (i_offset == IO_LED_REG))
				led_reg <= i_wdata;
			// Keep the address behind the latest bus error
			if (i_miss_stb)
				err_addr <= i_bus_addr;
		end
	end

	// LEDs follow the low nibble
	assign o_led = led_reg[3:0];

	//////////////////////////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
		begin
			case (i_offset)
				// Buttons high nibble, switches low nibble
				IO_SW_REG:  o_rdata <= {24'h0, i_btn, i_sw};
				IO_LED_REG: o_rdata <= led_reg;
				IO_ERR_REG: o_rdata <= err_addr;
				// Unused offsets read zero
				default:    o_rdata <= '0;
			endcase
		end
	end

endmodule

// ==== src/cycle_counter.sv ====
// Loadable free-running clock cycle counter slave

module cycle_counter (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_stb,
	input  logic              i_we,
	input  fabric_pkg::data_t i_wdata,
	output logic              o_ack,
	output fabric_pkg::data_t o_rdata
);
	import fabric_pkg::*;

	data_t count;
	data_t count_next;

	// Wraps at 2^32
	assign count_next = count + 32'd1;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			count <= '0;
			o_ack <= 1'b0;
		end
		else
		begin
			o_ack <= i_stb;
			// Load on write, else count every clock
			if (i_stb && i_we)
				count <= i_wdata;
			else
				count <= count_next;
		end
	end

	// Value the counter takes at the strobe edge
	always_ff @(posedge i_clk)
	begin
		if (i_stb && !i_we)
			o_rdata <= count_next;
	end

endmodule

// ==== src/bus_fabric_top.sv ====
// Bus fabric top level
// Decoder, three slaves and the registered response path

module bus_fabric_top #(
	parameter int RAM_AW = 10
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_cyc,
	input  logic              i_stb,
	input  logic              i_we,
	input  fabric_pkg::addr_t i_addr,
	input  fabric_pkg::data_t i_wdata,
	input  fabric_pkg::led_t  i_sw,
	input  fabric_pkg::led_t  i_btn,
	output logic              o_ack,
	output logic              o_err,
	output fabric_pkg::data_t o_rdata,
	output fabric_pkg::led_t  o_led
);
	import fabric_pkg::*;

	// Per slave strobes
	logic ram_stb, io_stb, cnt_stb, miss_stb;
	// Slave responses
	logic  ram_ack, io_ack, cnt_ack;
	data_t ram_data, io_data, cnt_data;

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////
	addr_decoder #(.RAM_AW(RAM_AW)) u_dec (
		.i_cyc(i_cyc), .i_stb(i_stb), .i_addr(i_addr),
		.o_ram_stb(ram_stb), .o_io_stb(io_stb),
		.o_cnt_stb(cnt_stb), .o_miss_stb(miss_stb)
	);

	//////////////////////////////////////////////////////////////////////
	// Slaves
	//////////////////////////////////////////////////////////////////////
	block_ram #(.RAM_AW(RAM_AW)) u_ram (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_stb(ram_stb), .i_we(i_we),
		.i_addr(i_addr[RAM_AW-1:0]), .i_wdata(i_wdata),
		.o_ack(ram_ack), .o_rdata(ram_data)
	);

	// Sees the miss strobe to keep the faulting address
	board_io u_io (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_stb(io_stb), .i_we(i_we),
		.i_offset(i_addr[2:0]), .i_wdata(i_wdata),
		.i_sw(i_sw), .i_btn(i_btn),
		.i_miss_stb(miss_stb), .i_bus_addr(i_addr),
		.o_ack(io_ack), .o_rdata(io_data), .o_led(o_led)
	);

	cycle_counter u_cnt (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_stb(cnt_stb), .i_we(i_we),
		.i_wdata(i_wdata), .o_ack(cnt_ack), .o_rdata(cnt_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Response back to the master
	//////////////////////////////////////////////////////////////////////
	resp_mux u_resp (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_ram_ack(ram_ack), .i_io_ack(io_ack), .i_cnt_ack(cnt_ack),
		.i_ram_data(ram_data), .i_io_data(io_data), .i_cnt_data(cnt_data),
		.i_miss_stb(miss_stb),
		.o_ack(o_ack), .o_err(o_err), .o_rdata(o_rdata)
	);

endmodule

// ==== test/tb_clock_gen.sv ====
// Testbench clock and reset source
// Free-running clock, reset held low for the first cycles

module tb_clock_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 2
) (
	output logic o_clk,
	output logic o_arst_n
);
	initial
	begin
		o_clk    = 1'b0;
		o_arst_n = 1'b0;
		// Release lands on a falling edge
		#(PERIOD * RST_CYCLES) o_arst_n = 1'b1;
	end

	always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// ==== test/bus_fabric_checker.sv ====
// Bus protocol checks, bound into the fabric top level

module bus_fabric_checker (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_cyc,
	input logic i_stb,
	input logic i_ram_ack,
	input logic i_io_ack,
	input logic i_cnt_ack,
	input logic i_ack,
	input logic i_err
);
	// Failed assertions, read back by the testbench
	int unsigned fail_count = 0;

	//////////////////////////////////////////////////////////////////////
	// Slave side
	//////////////////////////////////////////////////////////////////////

	// Disjoint regions, so at most one slave answers
	ack_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$onehot0({i_ram_ack, i_io_ack, i_cnt_ack}))
	else
	begin
		fail_count++;
		$error("more than one slave ack in a cycle");
	end

	//////////////////////////////////////////////////////////////////////
	// Master side
	//////////////////////////////////////////////////////////////////////
	ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_ack && i_err))
	else
	begin
		fail_count++;
		$error("ack and error raised together");
	end

	// Fixed two cycle latency, one answer per strobe
	stb_answered: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_cyc && i_stb) |-> ##2 (i_ack ^ i_err))
	else
	begin
		fail_count++;
		$error("strobe not answered two cycles later");
	end

	// Quiet response lines right out of reset
	reset_quiet: assert property (@(posedge i_clk)
		$rose(i_arst_n) |-> (!i_ack && !i_err) ##1 (!i_ack && !i_err))
	else
	begin
		fail_count++;
		$error("response active just after reset");
	end

endmodule

bind bus_fabric_top bus_fabric_checker u_chk (
	.i_clk(i_clk), .i_arst_n(i_arst_n), .i_cyc(i_cyc), .i_stb(i_stb),
	.i_ram_ack(ram_ack), .i_io_ack(io_ack), .i_cnt_ack(cnt_ack),
	.i_ack(o_ack), .i_err(o_err)
);

// ==== test/bus_fabric_tb.sv ====
// Bus fabric testbench
// Random transfers against a reference model, responses compared in order

module bus_fabric_tb;
	import fabric_pkg::*;

	localparam int RAM_AW = 10;
	localparam int SEED   = 5;
	localparam int N_RAM  = 64;
	// Reset, RAM passes, board I/O, bus error, counter
	localparam int N_XFERS  = 2 + 4 * N_RAM + 16 + 6 + 8;
	localparam int WATCHDOG = (N_XFERS * 3 + 100) * 20;

	// One expected response, due at a cycle number
	typedef struct packed {
		logic        err;
		logic        chk;
		data_t       data;
		logic [31:0] due;
	} resp_t;

	logic  clk, arst_n, cyc, stb, we, ack, err;
	addr_t addr;
	data_t wdata, rdata;
	led_t  sw, btn, led;

	// Reference model state
	data_t       ram_shadow [2 ** RAM_AW];
	data_t       led_shadow;
	addr_t       miss_shadow;
	data_t       cnt_load;
	int unsigned cnt_cyc;
	int unsigned cyc_num = 0;
	int unsigned errors;
	int unsigned checks;
	resp_t       pending [$];
	addr_t       used [$];

	tb_clock_gen #(.PERIOD(20), .RST_CYCLES(2)) u_clk (.o_clk(clk), .o_arst_n(arst_n));

	bus_fabric_top #(.RAM_AW(RAM_AW)) dut0 (
		.i_clk(clk), .i_arst_n(arst_n), .i_cyc(cyc), .i_stb(stb), .i_we(we),
		.i_addr(addr), .i_wdata(wdata), .i_sw(sw), .i_btn(btn),
		.o_ack(ack), .o_err(err), .o_rdata(rdata), .o_led(led)
	);

	// Rising edges seen so far
	always @(posedge clk)
		cyc_num++;

	task automatic log_error(input string msg);
		errors++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	// RAM window of 2^RAM_AW words from its base
	function automatic logic in_ram(addr_t a);
		return (a >= RAM_BASE) && (a < RAM_BASE + (2 ** RAM_AW));
	endfunction

	function automatic logic mapped(addr_t a);
		return in_ram(a) || ((a >= IO_BASE) && (a < IO_BASE + 8)) || (a == CNT_BASE);
	endfunction

	// Read result of a mapped address sampled at cycle at
	function automatic data_t predict_read(addr_t a, int unsigned at);
		if (in_ram(a))
			return ram_shadow[a[RAM_AW-1:0]];
		if (a == CNT_BASE)
			return cnt_load + data_t'(at - cnt_cyc);
		case (a[2:0])
			IO_SW_REG:  return {24'h0, btn, sw};
			IO_LED_REG: return led_shadow;
			IO_ERR_REG: return miss_shadow;
			default:    return '0;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// One transfer, driven at a falling edge, sampled at the next rise
	//////////////////////////////////////////////////////////////////////
	task automatic issue(input logic w, input addr_t a, input data_t d);
		resp_t       r;
		int unsigned at;
		at = cyc_num + 1;
		r.err = !mapped(a);
		r.chk = !w && !r.err;
		r.data = r.chk ? predict_read(a, at) : '0;
		r.due = at + 2;
		pending.push_back(r);
		if (r.err)
			miss_shadow = a;
		else if (w && in_ram(a))
			ram_shadow[a[RAM_AW-1:0]] = d;
		else if (w && a == IO_BASE + IO_LED_REG)
			led_shadow = d;
		else if (w && a == CNT_BASE)
		begin
			cnt_load = d;
			cnt_cyc = at;
		end
		cyc = 1'b1;
		stb = 1'b1;
		we = w;
		addr = a;
		wdata = d;
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic finish_test(input string name, input int unsigned err0);
		while (pending.size() != 0)
			@(negedge clk);
		@(negedge clk);
		$display("Test %-8s done, %0d errors", name, errors - err0);
	endtask

	// Compare the response slot of every cycle
	always @(negedge clk)
	begin : compare
		resp_t r;
		// Slot that the next rising edge samples
		if (pending.size() != 0 && pending[0].due == cyc_num + 1)
		begin
			r = pending.pop_front();
			checks++;
			assert (ack == !r.err && err == r.err)
			else
				log_error($sformatf("expected %s, got ack %b err %b",
					r.err ? "error" : "ack", ack, err));
			if (r.chk)
				assert (rdata == r.data)
				else
					log_error($sformatf("read data %h, expected %h", rdata, r.data));
		end
		else
			assert (!ack && !err)
			else
				log_error("response with no transfer due");
	end

	initial
	begin : watchdog
		#(WATCHDOG);
		$display("Watchdog expired with %0d responses outstanding", pending.size());
		$display("Errors found");
		$finish;
	end

	initial
	begin : stimulus
		int unsigned e0;
		int unsigned k;
		data_t       v;
		addr_t       a;
		void'($urandom(SEED));
		{cyc, stb, we, addr, wdata, sw, btn} = '0;
		{led_shadow, miss_shadow, cnt_load} = '0;
		{cnt_cyc, errors, checks} = '0;
		@(posedge arst_n);
		@(negedge clk);

		// Reset values
		e0 = errors;
		assert (led == '0) else log_error("LEDs not cleared by reset");
		issue(1'b0, IO_BASE + IO_ERR_REG, '0);
		issue(1'b0, IO_BASE + IO_LED_REG, '0);
		finish_test("reset", e0);

		// RAM with idle gaps, then a strobe every cycle
		e0 = errors;
		for (int i = 0; i < N_RAM; i++)
		begin
			a = RAM_BASE + ($urandom % (2 ** RAM_AW));
			used.push_back(a);
			issue(1'b1, a, $urandom);
			@(negedge clk);
		end
		foreach (used[i])
		begin
			issue(1'b0, used[i], '0);
			@(negedge clk);
		end
		foreach (used[i])
			issue(1'b1, used[i], $urandom);
		foreach (used[i])
			issue(1'b0, used[i], '0);
		finish_test("ram", e0);

		// LED register, switches and buttons, unused offsets
		e0 = errors;
		v = $urandom;
		issue(1'b1, IO_BASE + IO_LED_REG, v);
		assert (led == v[3:0]) else log_error("LEDs do not follow the LED register");
		issue(1'b0, IO_BASE + IO_LED_REG, '0);
		for (int i = 0; i < 4; i++)
		begin
			sw = $urandom;
			btn = $urandom;
			issue(1'b0, IO_BASE + IO_SW_REG, '0);
		end
		for (int i = 3; i < 8; i++)
		begin
			issue(1'b1, IO_BASE + i, $urandom);
			issue(1'b0, IO_BASE + i, '0);
		end
		finish_test("board_io", e0);

		// Unmapped strobes, first one right past the counter word
		e0 = errors;
		for (int i = 0; i < 3; i++)
		begin
			a = (i == 0) ? 32'h0000_0109 : 32'h0001_0000 + $urandom % 32'h1000;
			issue($urandom % 2, a, $urandom);
			issue(1'b0, IO_BASE + IO_ERR_REG, '0);
		end
		finish_test("bus_err", e0);

		// Load, wait k cycles, read back load plus k
		e0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			k = 1 + $urandom % 8;
			issue(1'b1, CNT_BASE, $urandom);
			repeat (k - 1) @(negedge clk);
			issue(1'b0, CNT_BASE, '0);
		end
		finish_test("counter", e0);

		errors += dut0.u_chk.fail_count;
		$display("Tests 5, responses checked %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== bus_fabric.f ====
src/fabric_pkg.sv
src/addr_decoder.sv
src/resp_mux.sv
src/block_ram.sv
src/board_io.sv
src/cycle_counter.sv
src/bus_fabric_top.sv
test/tb_clock_gen.sv
test/bus_fabric_checker.sv
test/bus_fabric_tb.sv

// ==== Bender.yml ====
package:
  name: bus_fabric

sources:
  - src/fabric_pkg.sv
  - src/addr_decoder.sv
  - src/resp_mux.sv
  - src/block_ram.sv
  - src/board_io.sv
  - src/cycle_counter.sv
  - src/bus_fabric_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/bus_fabric_checker.sv
      - test/bus_fabric_tb.sv
